//--- hdl/ringPkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types and codes for the ring memory path
// field widths, ring operations, access codes, bridge FSM states
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package ringPkg;

	// ring slot fields
	typedef logic [15:0]  ringSeqT;   // node id in [15:8], rolling count in [5:0]
	typedef logic [15:0]  ringOpmT;
	typedef logic [31:0]  ringAddrT;  // tile index in [27:4]
	typedef logic [127:0] tileT;
	typedef logic [23:0]  tileTagT;

	// access port
	typedef logic [4:0]   accOpmT;    // [4] store, [3] load, [2:0] size
	typedef logic [1:0]   accOkT;

	// ring operations, response class sits in bits 7:6
	localparam ringOpmT opIdle      = 16'h0000;
	localparam ringOpmT opLoadReq   = 16'h00B0;
	localparam ringOpmT opStoreReq  = 16'h00A0;
	localparam ringOpmT opLoadResp  = 16'h0070;
	localparam ringOpmT opStoreResp = 16'h0060;

	localparam logic [1:0] respClass = 2'b01;  // opm[7:6] of any response

	// access sizes
	localparam logic [2:0] szWord   = 3'b010;  // 32 bits
	localparam logic [2:0] szDouble = 3'b011;  // 64 bits
	localparam logic [2:0] szTile   = 3'b111;  // 128 bits

	// access status
	localparam accOkT okReady = 2'b00;  // no request
	localparam accOkT okDone  = 2'b01;
	localparam accOkT okHold  = 2'b10;  // repeat the same request

	// bridge miss handling
	typedef enum logic [1:0]
	{
		stIdle,
		stWriteBack,
		stFill
	} bridgeStateT;

endpackage

//--- hdl/tileBridge.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// load/store port to ring bridge with a one-tile write-back cache
// hits answer two cycles after the request, misses hold the requester
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tileBridge #(
	parameter logic [7:0] NODE_ID = 8'h21
)(
	input  logic              clock,
	input  logic              reset,

	input  ringPkg::ringAddrT accAddr,
	input  ringPkg::accOpmT   accOpm,
	input  logic [63:0]       accDataLo,
	input  logic [63:0]       accDataHi,
	output logic [63:0]       accDataOutLo,
	output logic [63:0]       accDataOutHi,
	output ringPkg::accOkT    accOk,

	input  ringPkg::ringSeqT  ringSeqIn,
	input  ringPkg::ringOpmT  ringOpmIn,
	input  ringPkg::ringAddrT ringAddrIn,
	input  ringPkg::tileT     ringDataIn,
	output ringPkg::ringSeqT  ringSeqOut,
	output ringPkg::ringOpmT  ringOpmOut,
	output ringPkg::ringAddrT ringAddrOut,
	output ringPkg::tileT     ringDataOut
);

	import ringPkg::*;

	// registered request
	ringAddrT    reqAddr;
	accOpmT      reqOpm;
	logic [63:0] reqDataLo;
	logic [63:0] reqDataHi;
	logic        skipReq;  // request sampled with the last okDone is stale

	// cached tile
	tileT        tileData;
	tileTagT     tileTag;
	logic        tileValid;
	logic        tileDirty;

	bridgeStateT state;
	logic        sent;     // request of the current state is on the ring
	logic [5:0]  seqCnt;

	tileTagT     reqTag;
	logic        reqActive;
	logic        hit;
	logic        storeHit;
	tileT        storeTile;
	logic [63:0] dataLoNext;
	logic [63:0] dataHiNext;
	accOkT       okNext;

	ringSeqT     mySeq;
	logic        respForUs;
	logic        respMatch;
	logic        slotFree;
	logic        sendNow;
	logic        wbDone;
	logic        fillDone;

	assign reqTag    = reqAddr[27:4];
	assign reqActive = (reqOpm[4:3] != 2'b00) && !skipReq;
	assign hit       = tileValid && (tileTag == reqTag) && (state == stIdle);
	assign storeHit  = reqActive && hit && reqOpm[4];
	assign okNext    = !reqActive ? okReady : (hit ? okDone : okHold);

	// ring side decode
	assign mySeq     = {NODE_ID, 2'b00, seqCnt};
	assign respForUs = (ringOpmIn[7:6] == respClass) && (ringSeqIn[15:8] == NODE_ID);
	assign respMatch = respForUs && (ringSeqIn == mySeq);
	assign slotFree  = (ringOpmIn == opIdle) || respForUs;  // idle or consumed here
	assign sendNow   = slotFree && (state != stIdle) && !sent;
	assign wbDone    = (state == stWriteBack) && sent && respMatch && (ringOpmIn == opStoreResp);
	assign fillDone  = (state == stFill) && sent && respMatch && (ringOpmIn == opLoadResp);

	// load lane select, right aligned and zero filled
	always_comb
	begin
		dataLoNext = '0;
		dataHiNext = '0;
		if (reqActive && hit && reqOpm[3])
		begin
			case (reqOpm[2:0])
				szTile:
				begin
					dataLoNext = tileData[63:0];
					dataHiNext = tileData[127:64];
				end
				szDouble: dataLoNext = tileData[{reqAddr[3], 6'b0} +: 64];
				default:  dataLoNext = {32'h0, tileData[{reqAddr[3:2], 5'b0} +: 32]};
			endcase
		end
	end

	// store merge into the tile
	always_comb
	begin
		storeTile = tileData;
		case (reqOpm[2:0])
			szTile:   storeTile = {reqDataHi, reqDataLo};
			szDouble: storeTile[{reqAddr[3], 6'b0} +: 64] = reqDataLo;
			default:  storeTile[{reqAddr[3:2], 5'b0} +: 32] = reqDataLo[31:0];
		endcase
	end

	// access side registers
	always_ff @(posedge clock)
	begin
		reqAddr      <= accAddr;
		reqDataLo    <= accDataLo;
		reqDataHi    <= accDataHi;
		accDataOutLo <= dataLoNext;
		accDataOutHi <= dataHiNext;
		if (reset)
		begin
			reqOpm  <= '0;
			skipReq <= 1'b0;
			accOk   <= okReady;
		end
		else
		begin
			reqOpm  <= accOpm;
			skipReq <= (okNext == okDone);
			accOk   <= okNext;
		end
	end

	// miss handling FSM
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state     <= stIdle;
			sent      <= 1'b0;
			seqCnt    <= '0;
			tileValid <= 1'b0;
			tileDirty <= 1'b0;
		end
		else
		begin
			case (state)
				stIdle:
				begin
					if (storeHit)
						tileDirty <= 1'b1;
					else if (reqActive && !hit)
					begin
						state <= tileDirty ? stWriteBack : stFill;
						sent  <= 1'b0;
					end
				end
				stWriteBack:
				begin
					if (sendNow)
						sent <= 1'b1;
					else if (wbDone)
					begin
						state  <= stFill;
						sent   <= 1'b0;
						seqCnt <= seqCnt + 6'd1;
					end
				end
				default:
				begin
					if (sendNow)
						sent <= 1'b1;
					else if (fillDone)
					begin
						state     <= stIdle;
						tileValid <= 1'b1;
						tileDirty <= 1'b0;
						seqCnt    <= seqCnt + 6'd1;
					end
				end
			endcase
		end
	end

	// tile contents, no reset
	always_ff @(posedge clock)
	begin
		if (storeHit)
			tileData <= storeTile;
		else if (fillDone)
		begin
			tileData <= ringDataIn;
			tileTag  <= ringAddrIn[27:4];
		end
	end

	// ring stop, one register stage
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			ringSeqOut  <= '0;
			ringOpmOut  <= opIdle;
			ringAddrOut <= '0;
			ringDataOut <= '0;
		end
		else if (sendNow)
		begin
			ringSeqOut <= mySeq;
			if (state == stWriteBack)
			begin
				ringOpmOut  <= opStoreReq;
				ringAddrOut <= {4'h0, tileTag, 4'h0};  // write back the old tile
				ringDataOut <= tileData;
			end
			else
			begin
				ringOpmOut  <= opLoadReq;
				ringAddrOut <= {4'h0, reqTag, 4'h0};
				ringDataOut <= '0;
			end
		end
		else if (respForUs)
		begin
			ringSeqOut  <= '0;  // consumed, leave an empty slot
			ringOpmOut  <= opIdle;
			ringAddrOut <= '0;
			ringDataOut <= '0;
		end
		else
		begin
			ringSeqOut  <= ringSeqIn;
			ringOpmOut  <= ringOpmIn;
			ringAddrOut <= ringAddrIn;
			ringDataOut <= ringDataIn;
		end
	end

endmodule

//--- hdl/ringMemory.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ring stop serving tile loads and stores from a block RAM
// each request slot leaves one cycle later as its response
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module ringMemory #(
	parameter int MEM_TILES = 16  // power of two
)(
	input  logic              clock,
	input  logic              reset,

	input  ringPkg::ringSeqT  ringSeqIn,
	input  ringPkg::ringOpmT  ringOpmIn,
	input  ringPkg::ringAddrT ringAddrIn,
	input  ringPkg::tileT     ringDataIn,
	output ringPkg::ringSeqT  ringSeqOut,
	output ringPkg::ringOpmT  ringOpmOut,
	output ringPkg::ringAddrT ringAddrOut,
	output ringPkg::tileT     ringDataOut
);

	import ringPkg::*;

	localparam int IDX_W = $clog2(MEM_TILES);

	tileT             mem [MEM_TILES];
	logic [IDX_W-1:0] memIdx;
	logic             isLoad;
	logic             isStore;

	tileT             memRead;   // synchronous read port
	tileT             slotData;  // data of forwarded or store slots
	logic             wasLoad;

	// address wraps modulo the memory size
	assign memIdx  = ringAddrIn[4 +: IDX_W];
	assign isLoad  = (ringOpmIn == opLoadReq);
	assign isStore = (ringOpmIn == opStoreReq);

	// RAM array
	always_ff @(posedge clock)
	begin
		if (isStore)
			mem[memIdx] <= ringDataIn;
		memRead <= mem[memIdx];  // read before write
	end

	// slot register
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			ringSeqOut  <= '0;
			ringOpmOut  <= opIdle;
			ringAddrOut <= '0;
			slotData    <= '0;
			wasLoad     <= 1'b0;
		end
		else
		begin
			ringSeqOut  <= ringSeqIn;  // sequence routes the reply home
			ringAddrOut <= ringAddrIn;
			slotData    <= ringDataIn;  // store reply carries the old slot data
			wasLoad     <= isLoad;
			if (isLoad)
				ringOpmOut <= opLoadResp;
			else if (isStore)
				ringOpmOut <= opStoreResp;
			else
				ringOpmOut <= ringOpmIn;
		end
	end

	// load replies take the RAM output
	assign ringDataOut = wasLoad ? memRead : slotData;

endmodule

//--- hdl/ringMemTop.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// top level, two-stop ring of bridge and tile memory
// requester attaches to the access port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module ringMemTop #(
	parameter logic [7:0] NODE_ID   = 8'h21,
	parameter int         MEM_TILES = 16
)(
	input  logic              clock,
	input  logic              reset,

	input  ringPkg::ringAddrT accAddr,
	input  ringPkg::accOpmT   accOpm,
	input  logic [63:0]       accDataLo,
	input  logic [63:0]       accDataHi,
	output logic [63:0]       accDataOutLo,
	output logic [63:0]       accDataOutHi,
	output ringPkg::accOkT    accOk
);

	import ringPkg::*;

	// bridge to memory
	ringSeqT  fwdSeq;
	ringOpmT  fwdOpm;
	ringAddrT fwdAddr;
	tileT     fwdData;

	// memory back to bridge
	ringSeqT  retSeq;
	ringOpmT  retOpm;
	ringAddrT retAddr;
	tileT     retData;

	tileBridge #(
		.NODE_ID (NODE_ID)
	) u_bridge (
		.clock        (clock),
		.reset        (reset),
		.accAddr      (accAddr),
		.accOpm       (accOpm),
		.accDataLo    (accDataLo),
		.accDataHi    (accDataHi),
		.accDataOutLo (accDataOutLo),
		.accDataOutHi (accDataOutHi),
		.accOk        (accOk),
		.ringSeqIn    (retSeq),
		.ringOpmIn    (retOpm),
		.ringAddrIn   (retAddr),
		.ringDataIn   (retData),
		.ringSeqOut   (fwdSeq),
		.ringOpmOut   (fwdOpm),
		.ringAddrOut  (fwdAddr),
		.ringDataOut  (fwdData)
	);

	ringMemory #(
		.MEM_TILES (MEM_TILES)
	) u_memory (
		.clock       (clock),
		.reset       (reset),
		.ringSeqIn   (fwdSeq),
		.ringOpmIn   (fwdOpm),
		.ringAddrIn  (fwdAddr),
		.ringDataIn  (fwdData),
		.ringSeqOut  (retSeq),
		.ringOpmOut  (retOpm),
		.ringAddrOut (retAddr),
		.ringDataOut (retData)
	);

endmodule

//--- testbench/tbSupport.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// stimulus, model and check helpers, included inside tbRingMem
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef TB_SUPPORT_SVH
`define TB_SUPPORT_SVH

// right shifting Galois LFSR
function automatic logic [31:0] lfsrStep(input logic [31:0] s);
	return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
endfunction

function automatic logic [63:0] randBits(input int n);
	logic [63:0] val;
	val = '0;
	for (int i = 0; i < n; i++)
	begin
		val       = {val[62:0], lfsrState[0]};  // one step per bit
		lfsrState = lfsrStep(lfsrState);
	end
	return val;
endfunction

task automatic checkValue(input string name, input logic [127:0] got, input logic [127:0] exp);
	checkCount++;
	if (got !== exp)
	begin
		errorCount++;
		$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
	end
endtask

task automatic endTest(input int num, input string name, input int errBefore);
	$display("test %0d %s: %0d errors", num, name, errorCount - errBefore);
endtask

// lane masks, {hi, lo} layout of a tile
function automatic logic [127:0] laneMask(input ringAddrT addr, input logic [2:0] size);
	if (size == szTile)
		return '1;
	if (size == szDouble)
		return {64'h0, 64'hffff_ffff_ffff_ffff} << {addr[3], 6'b0};
	return {96'h0, 32'hffff_ffff} << {addr[3:2], 5'b0};
endfunction

// drives one access, waits for okDone and checks or updates the model
task automatic accessAndCheck(input ringAddrT addr, input logic isStore, input logic [2:0] size,
	input logic [63:0] lo, input logic [63:0] hi, output int cycles);
	logic [3:0]   idx;
	logic [127:0] mask;
	logic [127:0] wide;
	logic [127:0] expData;
	idx       = addr[7:4];  // memory wraps at 16 tiles
	mask      = laneMask(addr, size);
	accAddr   = addr;
	accOpm    = isStore ? {2'b10, size} : {2'b01, size};
	accDataLo = lo;
	accDataHi = hi;
	cycles    = 0;
	do
	begin
		@(posedge clock);
		#1;
		cycles++;
		if (cycles > 1 && accOk != okDone)
			checkValue("accOk", 128'(accOk), 128'(okHold));  // waiting on a miss
	end
	while (accOk != okDone);
	if (isStore)
	begin
		wide        = (size == szTile) ? {hi, lo} : ({64'h0, lo} << {addr[3:0], 3'b000});
		refMem[idx] = (refMem[idx] & ~mask) | (wide & mask);
	end
	else
	begin
		expData = (refMem[idx] & mask) >> ((size == szTile) ? 7'd0 : {addr[3:0], 3'b000});
		checkValue("accDataOutLo", 128'(accDataOutLo), 128'(expData[63:0]));
		checkValue("accDataOutHi", 128'(accDataOutHi), 128'(expData[127:64]));
	end
	accessCount++;
	#1;  // next drive lands 2 ns after the edge
endtask

`endif

//--- testbench/tbRingMem.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the two-stop ring memory path
// random traffic from an LFSR, checked against a tile array model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tbRingMem;

	import ringPkg::*;

	localparam int     numAccesses = 32 + 300 + 2 + 3;
	localparam longint watchdogNs  = (numAccesses * 40 + 2000) * 20;

	logic        clock;
	logic        reset;
	ringAddrT    accAddr;
	accOpmT      accOpm;
	logic [63:0] accDataLo;
	logic [63:0] accDataHi;
	logic [63:0] accDataOutLo;
	logic [63:0] accDataOutHi;
	accOkT       accOk;

	int          errorCount;
	int          checkCount;
	int          accessCount;
	logic [31:0] lfsrState;
	tileT        refMem [16];  // expected memory contents

	`include "tbSupport.svh"

	ringMemTop #(
		.NODE_ID   (8'h21),
		.MEM_TILES (16)
	) u_dut (
		.clock        (clock),
		.reset        (reset),
		.accAddr      (accAddr),
		.accOpm       (accOpm),
		.accDataLo    (accDataLo),
		.accDataHi    (accDataHi),
		.accDataOutLo (accDataOutLo),
		.accDataOutHi (accDataOutHi),
		.accOk        (accOk)
	);

	always #10 clock = ~clock;  // 20 ns period

	// watchdog, sized from the number of accesses
	initial
	begin
		#(watchdogNs);
		$display("timeout: accesses did not finish within %0d ns", watchdogNs);
		$display("Simulation failed");
		$finish;
	end

	initial
	begin
		int          errBefore;
		int          cycles;
		logic [63:0] r;
		tileTagT     tag;
		logic [3:0]  low;
		logic [2:0]  size;
		logic [63:0] lo;
		logic [63:0] hi;

		clock       = 1'b0;
		reset       = 1'b1;
		accAddr     = '0;
		accOpm      = '0;
		accDataLo   = '0;
		accDataHi   = '0;
		lfsrState   = 32'h48e3;
		errorCount  = 0;
		checkCount  = 0;
		accessCount = 0;
		repeat (3) @(posedge clock);
		#2 reset = 1'b0;

		// idle port after reset
		errBefore = errorCount;
		repeat (2) @(posedge clock);
		#1;
		checkValue("accOk", 128'(accOk), 128'(okReady));
		checkValue("accDataOutLo", 128'(accDataOutLo), 128'h0);
		checkValue("accDataOutHi", 128'(accDataOutHi), 128'h0);
		#1;
		endTest(1, "reset state", errBefore);

		// fill all tiles, then read them back through misses
		errBefore = errorCount;
		for (int i = 0; i < 16; i++)
		begin
			lo = randBits(64);
			hi = randBits(64);
			accessAndCheck({24'h0, 4'(i), 4'h0}, 1'b1, szTile, lo, hi, cycles);
		end
		for (int i = 0; i < 16; i++)
			accessAndCheck({24'h0, 4'(i), 4'h0}, 1'b0, szTile, '0, '0, cycles);
		endTest(2, "initial fill", errBefore);

		errBefore = errorCount;
		for (int i = 0; i < 300; i++)
		begin
			r   = randBits(11);
			tag = {18'h0, r[5:4], r[3:0]};  // upper bits alias in memory
			case (r[7:6])
				2'b01:
				begin
					size = szDouble;
					low  = {r[9], 3'b000};
				end
				2'b10:
				begin
					size = szTile;
					low  = 4'h0;
				end
				default:
				begin
					size = szWord;
					low  = {r[9:8], 2'b00};
				end
			endcase
			lo = randBits(64);
			hi = randBits(64);
			accessAndCheck({4'h0, tag, low}, r[10], size, lo, hi, cycles);
		end
		endTest(3, "random traffic", errBefore);

		// second access to the same tile is a hit
		errBefore = errorCount;
		accessAndCheck(32'h0000_0090, 1'b0, szTile, '0, '0, cycles);
		accessAndCheck(32'h0000_0094, 1'b1, szWord, randBits(64), '0, cycles);
		checkValue("hitLatency", 128'(cycles), 128'd2);
		endTest(4, "hit timing", errBefore);

		// tiles 35 and 45 share a memory slot
		errBefore = errorCount;
		accessAndCheck(32'h0000_0354, 1'b1, szWord, randBits(64), '0, cycles);
		accessAndCheck(32'h0000_0450, 1'b0, szTile, '0, '0, cycles);
		accessAndCheck(32'h0000_0350, 1'b0, szTile, '0, '0, cycles);
		endTest(5, "eviction integrity", errBefore);

		accOpm = '0;
		$display("accesses %0d, checks %0d, errors %0d", accessCount, checkCount, errorCount);
		if (errorCount == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- flist.f
+incdir+testbench
hdl/ringPkg.sv
hdl/tileBridge.sv
hdl/ringMemory.sv
hdl/ringMemTop.sv
testbench/tbRingMem.sv

//--- run.sh
#!/bin/sh
# build and run the ring memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -f flist.f --top-module tbRingMem -Mdir obj_dir -o simRingMem
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/simRingMem > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Simulation passed$" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1
